/* filelist.f */
+incdir+rtl
rtl/d_cache_tq_pkg.sv
rtl/d_cache_tq_merge_buffer.sv
rtl/d_cache_tq_entry.sv
rtl/d_cache_tq_occupancy.sv
rtl/d_cache_rd_rsp_align.sv
rtl/d_cache_tq.sv
verif/d_cache_tq_tb.sv

/* rtl/d_cache_rd_rsp_align.sv */
// Core read response from a Q3 pipe response
// Word select, byte masking, sign or zero extension
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_rd_rsp_align (
    input  var d_cache_tq_pkg::t_lu_rsp lu_rsp,
    output d_cache_tq_pkg::t_rd_rsp     rd_rsp
);
    import d_cache_tq_pkg::*;

    t_word word_sel;
    t_word data_word;
    logic  sign_bit;    // Top bit of the byte below

    // Addressed word of the line
    assign word_sel = lu_rsp.cl_data[lu_rsp.address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]*`WORD_W
                                     +: `WORD_W];

    always_comb begin
        sign_bit = 1'b0;    // Byte 0 zero when disabled
        for (int b = 0; b < 4; b++) begin
            if (lu_rsp.byte_en[b])       data_word[b*8 +: 8] = word_sel[b*8 +: 8];
            else if (lu_rsp.sign_extend) data_word[b*8 +: 8] = {8{sign_bit}};
            else                         data_word[b*8 +: 8] = 8'h00;
            sign_bit = data_word[b*8+7];
        end
    end

    // Read hit, or a fill that carries a waiting read
    assign rd_rsp.valid   = lu_rsp.valid &&
                            (((lu_rsp.lu_op == RD_LU) && (lu_rsp.lu_result == HIT)) ||
                             ((lu_rsp.lu_op == FILL_LU) && lu_rsp.rd_indication));
    assign rd_rsp.address = lu_rsp.address;
    assign rd_rsp.data    = data_word;
    assign rd_rsp.reg_id  = lu_rsp.reg_id;

endmodule

/* rtl/d_cache_tq.sv */
// Transaction queue top level of the data cache
// Entry array, merge hit detection, free and fill pick, pipe lookup mux
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_tq (
    input  logic                                clk,
    input  logic                                rst_n,
    input  var d_cache_tq_pkg::t_req            core_req,
    output logic                                ready,
    output d_cache_tq_pkg::t_rd_rsp             cache2core_rsp,
    input  var d_cache_tq_pkg::t_fm_rd_rsp      fm_rsp,
    output d_cache_tq_pkg::t_lu_req             pipe_lu_req_q1,
    input  var d_cache_tq_pkg::t_lu_rsp         pipe_lu_rsp_q3
);
    import d_cache_tq_pkg::*;

    t_tq_state                                  entry_state   [`NUM_TQ_ENTRY];
    t_cl_address                                entry_cl_addr [`NUM_TQ_ENTRY];
    logic [`REG_ID_W-1:0]                       entry_reg_id  [`NUM_TQ_ENTRY];
    logic [`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]   entry_offset  [`NUM_TQ_ENTRY];
    t_cl_data                                   entry_data    [`NUM_TQ_ENTRY];
    logic [`NUM_TQ_ENTRY-1:0]                   entry_rd_ind;
    logic [`NUM_TQ_ENTRY-1:0]                   entry_release;
    logic [`NUM_TQ_ENTRY-1:0]                   merge_hit;
    logic [`NUM_TQ_ENTRY-1:0]                   allocate;
    logic [`NUM_TQ_ENTRY-1:0]                   fill_issue;
    logic                                       full;
    logic                                       accept;       // Request taken this cycle
    logic                                       any_merge;
    logic                                       free_found;
    logic                                       fill_found;
    t_tq_id                                     first_free_id;
    t_tq_id                                     first_fill_id;

    assign ready     = !full;
    assign accept    = core_req.valid && ready;
    assign any_merge = |merge_hit;

    //==========================================================================
    // Merge hit and entry pick
    //==========================================================================
    always_comb begin
        free_found    = 1'b0;
        fill_found    = 1'b0;
        first_free_id = '0;
        first_fill_id = '0;
        for (int i = `NUM_TQ_ENTRY-1; i >= 0; i--) begin   // Downward so lowest wins
            merge_hit[i] = core_req.valid &&
                           (core_req.address[`ADDR_W-1:`LSB_SET] == entry_cl_addr[i]) &&
                           ((entry_state[i] == S_MB_WAIT_FILL) ||
                            (entry_state[i] == S_MB_FILL_READY));
            if (entry_state[i] == S_IDLE) begin
                free_found    = 1'b1;
                first_free_id = t_tq_id'(i);
            end
            if (entry_state[i] == S_MB_FILL_READY) begin
                fill_found    = 1'b1;
                first_fill_id = t_tq_id'(i);
            end
        end
        for (int i = 0; i < `NUM_TQ_ENTRY; i++) begin
            allocate[i]   = accept && !any_merge && free_found && (first_free_id == t_tq_id'(i));
            fill_issue[i] = !accept && fill_found && (first_fill_id == t_tq_id'(i));  // Core first
        end
    end

    for (genvar g = 0; g < `NUM_TQ_ENTRY; g++) begin : g_entry
        d_cache_tq_entry entry (
            .clk            (clk),
            .rst_n          (rst_n),
            .entry_id       (t_tq_id'(g)),
            .core_req       (core_req),
            .allocate       (allocate[g]),
            .merge          (accept && merge_hit[g]),
            .fm_rsp         (fm_rsp),
            .pipe_lu_rsp_q3 (pipe_lu_rsp_q3),
            .fill_issue     (fill_issue[g]),
            .state          (entry_state[g]),
            .cl_address     (entry_cl_addr[g]),
            .rd_indication  (entry_rd_ind[g]),
            .reg_id         (entry_reg_id[g]),
            .word_offset    (entry_offset[g]),
            .fill_data      (entry_data[g]),
            .release_entry  (entry_release[g])
        );
    end

    d_cache_tq_occupancy occupancy (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (|allocate),
        .release_entry (|entry_release),   // One Q3 response per cycle
        .full          (full)
    );

    d_cache_rd_rsp_align rd_rsp_align (
        .lu_rsp (pipe_lu_rsp_q3),
        .rd_rsp (cache2core_rsp)
    );

    //==========================================================================
    // Pipe lookup mux, core request over fill
    //==========================================================================
    always_comb begin
        pipe_lu_req_q1 = '0;
        if (accept && !any_merge) begin
            pipe_lu_req_q1.valid         = 1'b1;
            pipe_lu_req_q1.lu_op         = (core_req.opcode == WR_OP) ? WR_LU : RD_LU;
            pipe_lu_req_q1.tq_id         = first_free_id;
            pipe_lu_req_q1.address       = core_req.address;
            pipe_lu_req_q1.data          = core_req.data;
            pipe_lu_req_q1.byte_en       = core_req.byte_en;
            pipe_lu_req_q1.sign_extend   = core_req.sign_extend;
            pipe_lu_req_q1.rd_indication = (core_req.opcode == RD_OP);
            pipe_lu_req_q1.wr_indication = (core_req.opcode == WR_OP);
            pipe_lu_req_q1.reg_id        = core_req.reg_id;
        end else if (!accept && fill_found) begin
            pipe_lu_req_q1.valid         = 1'b1;
            pipe_lu_req_q1.lu_op         = FILL_LU;
            pipe_lu_req_q1.tq_id         = first_fill_id;
            pipe_lu_req_q1.address       = {entry_cl_addr[first_fill_id],
                                            entry_offset[first_fill_id],
                                            {`LSB_WORD_OFFSET{1'b0}}};   // Waiting read's word
            pipe_lu_req_q1.cl_data       = entry_data[first_fill_id];
            pipe_lu_req_q1.byte_en       = 4'b1111;                      // Whole word back
            pipe_lu_req_q1.rd_indication = entry_rd_ind[first_fill_id];
            pipe_lu_req_q1.reg_id        = entry_reg_id[first_fill_id];
        end
    end

    // Only one read may wait on a line, so nothing merges into a read-marked entry
    a_no_merge_on_rd: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !(|(merge_hit & entry_rd_ind)));

endmodule

/* rtl/d_cache_tq_entry.sv */
// One transaction queue entry
// State machine from allocation to release, request identity, merge buffer
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_tq_entry (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  d_cache_tq_pkg::t_tq_id                      entry_id,
    input  var d_cache_tq_pkg::t_req                    core_req,
    input  logic                                        allocate,
    input  logic                                        merge,
    input  var d_cache_tq_pkg::t_fm_rd_rsp              fm_rsp,
    input  var d_cache_tq_pkg::t_lu_rsp                 pipe_lu_rsp_q3,
    input  logic                                        fill_issue,
    output d_cache_tq_pkg::t_tq_state                   state,
    output d_cache_tq_pkg::t_cl_address                 cl_address,
    output logic                                        rd_indication,
    output logic [`REG_ID_W-1:0]                        reg_id,
    output logic [`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]    word_offset,
    output d_cache_tq_pkg::t_cl_data                    fill_data,
    output logic                                        release_entry
);
    import d_cache_tq_pkg::*;

    logic own_q3;       // Q3 response for this entry
    logic own_fm;       // Fill memory return for this entry
    logic hit_q3;
    logic miss_q3;
    logic fill_q3;
    logic rd_merge;

    assign own_q3   = pipe_lu_rsp_q3.valid && (pipe_lu_rsp_q3.tq_id == entry_id);
    assign own_fm   = fm_rsp.valid && (fm_rsp.tq_id == entry_id);
    assign hit_q3   = own_q3 && (pipe_lu_rsp_q3.lu_result == HIT);
    assign miss_q3  = own_q3 && (pipe_lu_rsp_q3.lu_result == MISS);
    assign fill_q3  = own_q3 && (pipe_lu_rsp_q3.lu_result == FILL);
    assign rd_merge = merge && (core_req.opcode == RD_OP);

    // Release in the cycle of the closing response
    assign release_entry = (hit_q3 && (state == S_LU_CORE)) ||
                           (fill_q3 && (state == S_FILL_LU));

    //==========================================================================
    // Transaction state machine
    //==========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            rd_indication <= 1'b0;
        end else begin
            case (state)
                S_IDLE:          if (allocate) state <= S_LU_CORE;
                S_LU_CORE: begin
                    if (hit_q3)       state <= S_IDLE;           // Done, no miss
                    else if (miss_q3) state <= S_MB_WAIT_FILL;   // Wait for the line
                end
                S_MB_WAIT_FILL:  if (own_fm) state <= S_MB_FILL_READY;
                S_MB_FILL_READY: if (fill_issue) state <= S_FILL_LU;
                S_FILL_LU:       if (fill_q3) state <= S_IDLE;
                default:         state <= S_IDLE;
            endcase
            // A read owner or a merged read gets the line on the fill
            if (allocate)      rd_indication <= (core_req.opcode == RD_OP);
            else if (rd_merge) rd_indication <= 1'b1;
        end
    end

    // Request identity
    always_ff @(posedge clk) begin
        if (allocate) cl_address <= core_req.address[`ADDR_W-1:`LSB_SET];
        if (allocate || rd_merge) begin
            reg_id      <= core_req.reg_id;                                    // Read destination
            word_offset <= core_req.address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET];
        end
    end

    d_cache_tq_merge_buffer merge_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (allocate),
        .wr_en       ((allocate || merge) && (core_req.opcode == WR_OP)),
        .word_offset (core_req.address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]),
        .wr_data     (core_req.data),
        .byte_en     (core_req.byte_en),
        .fill_en     (own_fm && (state == S_MB_WAIT_FILL)),
        .fill_data   (fm_rsp.cl_data),
        .cl_data     (fill_data)
    );

    // Pipe and FM responses only arrive where this entry expects them
    a_lookup_rsp_state: assert property (@(posedge clk) disable iff (!rst_n)
        (hit_q3 || miss_q3) |-> (state == S_LU_CORE));
    a_fill_rsp_state: assert property (@(posedge clk) disable iff (!rst_n)
        fill_q3 |-> (state == S_FILL_LU));
    a_fm_rsp_state: assert property (@(posedge clk) disable iff (!rst_n)
        own_fm |-> (state == S_MB_WAIT_FILL));

endmodule

/* rtl/d_cache_tq_macros.svh */
// Size definitions of the data cache transaction queue
// Queue depth, line and word widths, address field positions
`ifndef D_CACHE_TQ_MACROS_SVH
`define D_CACHE_TQ_MACROS_SVH

// Queue sizing
`define NUM_TQ_ENTRY     4
`define TQ_ID_W          2

// Line and word
`define CL_W             128
`define CL_BYTES         16
`define WORD_W           32

// Address fields
`define ADDR_W           20
`define LSB_WORD_OFFSET  2   // Word select within the line
`define MSB_WORD_OFFSET  3
`define LSB_SET          4   // First line address bit
`define REG_ID_W         5   // Destination register id

`endif

/* rtl/d_cache_tq_merge_buffer.sv */
// Per-entry line store with a byte valid mask
// Merges core writes, overlays fill data under the written bytes
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_tq_merge_buffer (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        clear,
    input  logic                                        wr_en,
    input  logic [`MSB_WORD_OFFSET:`LSB_WORD_OFFSET]    word_offset,
    input  d_cache_tq_pkg::t_word                       wr_data,
    input  logic [3:0]                                  byte_en,
    input  logic                                        fill_en,
    input  d_cache_tq_pkg::t_cl_data                    fill_data,
    output d_cache_tq_pkg::t_cl_data                    cl_data
);
    import d_cache_tq_pkg::*;

    logic [`CL_BYTES-1:0] byte_valid;   // Bytes owned by core writes
    logic [`CL_BYTES-1:0] wr_sel;       // Line bytes written this cycle

    // Place the word's byte enables at the addressed word
    assign wr_sel = wr_en ? (`CL_BYTES'(byte_en) << {word_offset, 2'b00}) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_valid <= '0;
        end else if (clear) begin
            byte_valid <= wr_sel;               // New owner, maybe with its own write
        end else begin
            byte_valid <= byte_valid | wr_sel;
        end
    end

    //==========================================================================
    // Line data, write bytes beat fill bytes
    //==========================================================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CL_BYTES; i++) begin
            if (wr_sel[i]) begin
                cl_data[i*8 +: 8] <= wr_data[(i%4)*8 +: 8];
            end else if (fill_en && !byte_valid[i]) begin
                cl_data[i*8 +: 8] <= fill_data[i*8 +: 8];   // Only holes take fill data
            end
        end
    end

endmodule

/* rtl/d_cache_tq_occupancy.sv */
// Busy entry counter of the transaction queue
// Raises full when every entry is taken
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_tq_occupancy (
    input  logic clk,
    input  logic rst_n,
    input  logic alloc,
    input  logic release_entry,
    output logic full
);
    logic [`TQ_ID_W:0] count;   // One bit wider than the index to reach the depth

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (alloc && !release_entry) begin
            count <= count + 1'b1;
        end else if (!alloc && release_entry) begin
            count <= count - 1'b1;
        end
    end

    assign full = (count == (`TQ_ID_W+1)'(`NUM_TQ_ENTRY));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        release_entry |-> (count != '0));
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !full);

endmodule

/* rtl/d_cache_tq_pkg.sv */
// Shared types of the data cache transaction queue
// Opcodes, lookup ops and results, entry states
// Core, pipe and fill memory transaction structs
`include "d_cache_tq_macros.svh"

package d_cache_tq_pkg;

    typedef logic [`TQ_ID_W-1:0]            t_tq_id;
    typedef logic [`ADDR_W-`LSB_SET-1:0]    t_cl_address;   // Address bits above the line offset
    typedef logic [`WORD_W-1:0]             t_word;
    typedef logic [`CL_W-1:0]               t_cl_data;

    typedef enum logic [1:0] {
        RD_OP = 2'b00,
        WR_OP = 2'b01
    } t_opcode;

    typedef enum logic [1:0] {
        NO_LU   = 2'b00,
        RD_LU   = 2'b01,
        WR_LU   = 2'b10,
        FILL_LU = 2'b11   // Line install after the fill memory returned
    } t_lu_op;

    typedef enum logic [1:0] {
        NO_RESULT = 2'b00,
        HIT       = 2'b01,
        MISS      = 2'b10,
        FILL      = 2'b11
    } t_lu_result;

    typedef enum logic [2:0] {
        S_IDLE          = 3'd0,
        S_LU_CORE       = 3'd1,   // Core lookup in flight
        S_MB_WAIT_FILL  = 3'd2,   // Missed, merge buffer open
        S_MB_FILL_READY = 3'd3,   // Line returned, fill lookup pending
        S_FILL_LU       = 3'd4    // Fill lookup in flight
    } t_tq_state;

    //==========================================================================
    // Transaction structs
    //==========================================================================
    typedef struct packed {
        logic                   valid;
        t_opcode                opcode;
        logic [`ADDR_W-1:0]     address;
        t_word                  data;
        logic [3:0]             byte_en;
        logic                   sign_extend;
        logic [`REG_ID_W-1:0]   reg_id;
    } t_req;

    typedef struct packed {
        logic                   valid;
        t_lu_op                 lu_op;
        t_tq_id                 tq_id;
        logic [`ADDR_W-1:0]     address;
        t_word                  data;
        t_cl_data               cl_data;        // Merged line, fill lookups only
        logic [3:0]             byte_en;
        logic                   sign_extend;
        logic                   rd_indication;
        logic                   wr_indication;
        logic [`REG_ID_W-1:0]   reg_id;
    } t_lu_req;

    typedef struct packed {
        logic                   valid;
        t_lu_op                 lu_op;
        t_lu_result             lu_result;
        t_tq_id                 tq_id;
        logic [`ADDR_W-1:0]     address;
        t_cl_data               cl_data;
        logic [3:0]             byte_en;
        logic                   sign_extend;
        logic                   rd_indication;
        logic [`REG_ID_W-1:0]   reg_id;
    } t_lu_rsp;

    typedef struct packed {
        logic                   valid;
        t_tq_id                 tq_id;
        t_cl_data               cl_data;
    } t_fm_rd_rsp;

    typedef struct packed {
        logic                   valid;
        logic [`ADDR_W-1:0]     address;
        t_word                  data;
        logic [`REG_ID_W-1:0]   reg_id;
    } t_rd_rsp;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the transaction queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module d_cache_tq_tb \
    -f filelist.f \
    -o sim_d_cache_tq

# A $fatal in the testbench gives a failing exit status
./obj_dir/sim_d_cache_tq

/* verif/d_cache_tq_tb.sv */
// Testbench of the data cache transaction queue
// Plays core, lookup pipe and fill memory from a table of steps
// Reference model of entry lines, byte masks and read responses
`timescale 1ns/100ps
`include "d_cache_tq_macros.svh"

module d_cache_tq_tb;
    import d_cache_tq_pkg::*;

    localparam int WAIT_LIMIT = 50;   // Cycles per lookup wait

    typedef enum int {K_REQ, K_Q3, K_FM, K_WAIT_LU} step_kind;

    typedef struct {
        step_kind               kind;
        int                     id;         // Expected tq_id or merge target
        t_opcode                opcode;
        logic [`ADDR_W-1:0]     addr;
        logic [3:0]             byte_en;
        logic                   sign_extend;
        logic [`REG_ID_W-1:0]   reg_id;
        logic                   exp_lu;     // Request must produce a lookup
        logic                   exp_ready;
        t_lu_op                 lu_op;      // Lookup awaited by K_WAIT_LU
        t_lu_result             result;     // Q3 result to return
    } step_t;

    logic       clk;
    logic       rst_n;
    t_req       core_req;
    logic       ready;
    t_rd_rsp    cache2core_rsp;
    t_fm_rd_rsp fm_rsp;
    t_lu_req    pipe_lu_req_q1;
    t_lu_rsp    pipe_lu_rsp_q3;

    step_t              steps[$];
    logic [31:0]        lfsr = 32'd92832;
    logic               req_taken;          // Core request accepted in the last cycle

    // Reference model, one slot per entry
    t_cl_data               m_line [`NUM_TQ_ENTRY];
    logic [`CL_BYTES-1:0]   m_mask [`NUM_TQ_ENTRY];
    t_cl_data               m_fm   [`NUM_TQ_ENTRY];
    logic                   m_rd   [`NUM_TQ_ENTRY];
    logic [`REG_ID_W-1:0]   m_reg  [`NUM_TQ_ENTRY];
    logic [1:0]             m_off  [`NUM_TQ_ENTRY];
    t_cl_address            m_cla  [`NUM_TQ_ENTRY];
    t_lu_req                rec    [`NUM_TQ_ENTRY];   // Last lookup seen per entry

    d_cache_tq DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (core_req),
        .ready          (ready),
        .cache2core_rsp (cache2core_rsp),
        .fm_rsp         (fm_rsp),
        .pipe_lu_req_q1 (pipe_lu_req_q1),
        .pipe_lu_rsp_q3 (pipe_lu_rsp_q3)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //==========================================================================
    // Helpers
    //==========================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    task automatic take_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Byte rule of the core response
    function automatic t_word shape_word(input t_cl_data line, input logic [1:0] off,
                                         input logic [3:0] be, input logic se);
        t_word w;
        t_word res;
        logic  top;
        w   = line[off*32 +: 32];
        top = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (be[b])   res[b*8 +: 8] = w[b*8 +: 8];
            else if (se) res[b*8 +: 8] = {8{top}};
            else         res[b*8 +: 8] = 8'h00;
            top = res[b*8+7];
        end
        return res;
    endfunction

    function automatic step_t req_step(input t_opcode op, input logic [`ADDR_W-1:0] addr,
                                       input logic [3:0] be, input logic se,
                                       input logic [`REG_ID_W-1:0] rg, input int id,
                                       input logic exp_lu, input logic exp_ready);
        step_t s;
        s = '{K_REQ, id, op, addr, be, se, rg, exp_lu, exp_ready, NO_LU, NO_RESULT};
        return s;
    endfunction

    function automatic step_t q3_step(input int id, input t_lu_result res);
        step_t s;
        s = '{K_Q3, id, RD_OP, '0, '0, 1'b0, '0, 1'b0, 1'b1, NO_LU, res};
        return s;
    endfunction

    function automatic step_t fm_step(input int id);
        step_t s;
        s = '{K_FM, id, RD_OP, '0, '0, 1'b0, '0, 1'b0, 1'b1, NO_LU, NO_RESULT};
        return s;
    endfunction

    function automatic step_t wait_step(input int id, input t_lu_op op);
        step_t s;
        s = '{K_WAIT_LU, id, RD_OP, '0, '0, 1'b0, '0, 1'b1, 1'b1, op, NO_RESULT};
        return s;
    endfunction

    // New cycle, pulses end and an accepted request is withdrawn
    task automatic begin_cycle();
        @(posedge clk);
        fm_rsp         <= '0;
        pipe_lu_rsp_q3 <= '0;
        if (req_taken) core_req.valid <= 1'b0;
        req_taken = 1'b0;
    endtask

    task automatic note_accept(input int id, input logic merged);
        logic [1:0] off;
        off = core_req.address[`MSB_WORD_OFFSET:`LSB_WORD_OFFSET];
        if (!merged) begin                         // Fresh owner
            m_mask[id] = '0;
            m_rd[id]   = 1'b0;
            m_cla[id]  = core_req.address[`ADDR_W-1:`LSB_SET];
        end
        if (!merged || core_req.opcode == RD_OP) begin
            m_reg[id] = core_req.reg_id;
            m_off[id] = off;
        end
        if (core_req.opcode == RD_OP) m_rd[id] = 1'b1;
        else begin
            for (int b = 0; b < 4; b++) begin
                if (core_req.byte_en[b]) begin
                    m_line[id][(off*4+b)*8 +: 8] = core_req.data[b*8 +: 8];
                    m_mask[id][off*4+b]          = 1'b1;
                end
            end
        end
        req_taken = 1'b1;
    endtask

    task automatic check_core_lookup(input int id);
        check_value("lookup valid", pipe_lu_req_q1.valid, 1'b1);
        check_value("lookup op", pipe_lu_req_q1.lu_op,
                    (core_req.opcode == WR_OP) ? WR_LU : RD_LU);
        check_value("lookup tq_id", pipe_lu_req_q1.tq_id, id);
        check_value("lookup address", pipe_lu_req_q1.address, core_req.address);
        check_value("lookup data", pipe_lu_req_q1.data, core_req.data);
        check_value("lookup byte_en", pipe_lu_req_q1.byte_en, core_req.byte_en);
        check_value("lookup sign_extend", pipe_lu_req_q1.sign_extend, core_req.sign_extend);
        check_value("lookup reg_id", pipe_lu_req_q1.reg_id, core_req.reg_id);
        rec[id] = pipe_lu_req_q1;
        note_accept(id, 1'b0);
    endtask

    task automatic check_fill_lookup(input int id);
        t_cl_data exp_line;
        for (int i = 0; i < `CL_BYTES; i++) begin   // Merged bytes over the FM line
            exp_line[i*8 +: 8] = m_mask[id][i] ? m_line[id][i*8 +: 8] : m_fm[id][i*8 +: 8];
        end
        check_value("fill op", pipe_lu_req_q1.lu_op, FILL_LU);
        check_value("fill tq_id", pipe_lu_req_q1.tq_id, id);
        check_value("fill line", pipe_lu_req_q1.cl_data, exp_line);
        check_value("fill address", pipe_lu_req_q1.address, {m_cla[id], m_off[id], 2'b00});
        check_value("fill byte_en", pipe_lu_req_q1.byte_en, 4'b1111);   // Whole word
        check_value("fill rd_indication", pipe_lu_req_q1.rd_indication, m_rd[id]);
        check_value("fill reg_id", pipe_lu_req_q1.reg_id, m_reg[id]);
        rec[id] = pipe_lu_req_q1;
    endtask

    //==========================================================================
    // Step execution
    //==========================================================================
    task automatic run_step(input step_t s);
        t_req         r;
        t_lu_rsp      q;
        logic [127:0] rnd;
        logic         exp_rsp;
        int           n;
        case (s.kind)
            K_REQ: begin
                begin_cycle();
                take_bits(32, rnd);
                r = '{1'b1, s.opcode, s.addr, rnd[31:0], s.byte_en, s.sign_extend, s.reg_id};
                core_req <= r;
                @(negedge clk);
                check_value("ready", ready, s.exp_ready);
                if (s.exp_lu) check_core_lookup(s.id);
                else begin
                    check_value("no lookup", pipe_lu_req_q1.valid, 1'b0);
                    if (s.exp_ready) note_accept(s.id, 1'b1);   // Merged into the entry
                end
            end
            K_Q3: begin
                begin_cycle();
                take_bits(128, rnd);
                q = '0;
                q.valid         = 1'b1;
                q.lu_op         = rec[s.id].lu_op;
                q.lu_result     = s.result;
                q.tq_id         = t_tq_id'(s.id);
                q.address       = rec[s.id].address;
                q.cl_data       = (s.result == HIT) ? rnd :
                                  (s.result == FILL) ? rec[s.id].cl_data : '0;
                q.byte_en       = rec[s.id].byte_en;
                q.sign_extend   = rec[s.id].sign_extend;
                q.rd_indication = rec[s.id].rd_indication;
                q.reg_id        = rec[s.id].reg_id;
                pipe_lu_rsp_q3 <= q;
                exp_rsp = ((q.lu_op == RD_LU) && (s.result == HIT)) ||
                          ((q.lu_op == FILL_LU) && m_rd[s.id]);
                @(negedge clk);
                check_value("core rsp valid", cache2core_rsp.valid, exp_rsp);
                if (exp_rsp) begin
                    check_value("core rsp data", cache2core_rsp.data,
                                shape_word(q.cl_data, q.address[3:2], q.byte_en,
                                           q.sign_extend));
                    check_value("core rsp reg_id", cache2core_rsp.reg_id, m_reg[s.id]);
                    check_value("core rsp address", cache2core_rsp.address, q.address);
                end
            end
            K_FM: begin
                begin_cycle();
                take_bits(128, rnd);
                m_fm[s.id] = rnd;
                fm_rsp <= '{1'b1, t_tq_id'(s.id), rnd};
            end
            default: begin                      // Wait for the next lookup
                n = 0;
                do begin
                    begin_cycle();
                    @(negedge clk);
                    n++;
                end while (!pipe_lu_req_q1.valid && n < WAIT_LIMIT);
                if (!pipe_lu_req_q1.valid) begin
                    $display("Timeout: no pipe lookup for entry %0d within %0d cycles",
                             s.id, WAIT_LIMIT);
                    $display("Simulation failed");
                    $fatal(1, "Lookup wait timed out");
                end
                if (s.lu_op == FILL_LU) check_fill_lookup(s.id);
                else                    check_core_lookup(s.id);
            end
        endcase
    endtask

    //==========================================================================
    // Stimulus table and main sequence
    //==========================================================================
    initial begin
        core_req       = '0;
        fm_rsp         = '0;
        pipe_lu_rsp_q3 = '0;
        req_taken      = 1'b0;
        rst_n          = 1'b0;
        // Allocation, read hit, write miss
        steps.push_back(req_step(WR_OP, 20'h01234, 4'b1111, 1'b0, 5'd1, 0, 1'b1, 1'b1));
        steps.push_back(req_step(RD_OP, 20'h0456C, 4'b0011, 1'b1, 5'd2, 1, 1'b1, 1'b1));
        steps.push_back(q3_step(1, HIT));
        steps.push_back(q3_step(0, MISS));
        // Write and read merge, then the fill
        steps.push_back(req_step(WR_OP, 20'h01238, 4'b1010, 1'b0, 5'd3, 0, 1'b0, 1'b1));
        steps.push_back(req_step(RD_OP, 20'h01234, 4'b1111, 1'b0, 5'd7, 0, 1'b0, 1'b1));
        steps.push_back(fm_step(0));
        steps.push_back(wait_step(0, FILL_LU));
        steps.push_back(q3_step(0, FILL));
        // Four misses fill the queue
        for (int i = 0; i < 4; i++) begin
            steps.push_back(req_step(WR_OP, 20'h10000 * (i + 1) + 20'(4 * i), 4'b0110,
                                     1'b0, 5'(10 + i), i, 1'b1, 1'b1));
            steps.push_back(q3_step(i, MISS));
        end
        steps.push_back(req_step(RD_OP, 20'h50008, 4'b0001, 1'b1, 5'd9, 0, 1'b0, 1'b0));
        steps.push_back(fm_step(0));
        steps.push_back(wait_step(0, FILL_LU));
        steps.push_back(q3_step(0, FILL));
        steps.push_back(wait_step(0, RD_LU));    // Held request takes the freed entry
        steps.push_back(q3_step(0, HIT));
        // Core request beats a ready fill
        steps.push_back(fm_step(1));
        steps.push_back(req_step(WR_OP, 20'h60000, 4'b1111, 1'b0, 5'd4, 0, 1'b1, 1'b1));
        steps.push_back(wait_step(1, FILL_LU));
        steps.push_back(q3_step(1, FILL));
        steps.push_back(q3_step(0, HIT));
        // Drain what is left
        for (int i = 2; i < 4; i++) begin
            steps.push_back(fm_step(i));
            steps.push_back(wait_step(i, FILL_LU));
            steps.push_back(q3_step(i, FILL));
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) run_step(steps[i]);
        begin_cycle();
        @(negedge clk);
        check_value("ready at end", ready, 1'b1);
        check_value("idle lookup", pipe_lu_req_q1.valid, 1'b0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
